// File: sim.f
+incdir+.
arp_pkg.sv
arp_rx_parser.sv
arp_table.sv
arp_tx_select.sv
arp_tx_serializer.sv
arp_engine.sv
tb_arp_engine.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -f sim.f \
  --top-module tb_arp_engine -o tb_arp_engine \
  && ./obj_dir/tb_arp_engine > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "All checks passed" sim.log && echo "simulation PASSED" \
  || { echo "simulation FAILED"; exit 1; }

// File: tb_arp_tasks.svh
// expected frames built from the arp field rules
function automatic arp_hdr_t make_frame(input oper_t op, input mac_t sha, input ipv4_t spa,
                                        input mac_t tha, input ipv4_t tpa);
  return '{hw_type: 16'd1, proto: 16'h0800, hlen: 8'd6, plen: 8'd4, oper: op,
           sha: sha, spa: spa, tha: tha, tpa: tpa};
endfunction

function automatic arp_hdr_t reply_for(input arp_hdr_t rq);
  arp_hdr_t h;
  h = make_frame(16'd2, DEV_MAC, DEV_IP, rq.sha, rq.spa);
  h.proto = rq.proto; // echoed from the request
  h.plen  = rq.plen;
  return h;
endfunction

function automatic arp_hdr_t request_for(input ipv4_t ip);
  return make_frame(16'd1, DEV_MAC, DEV_IP, 48'hffff_ffff_ffff, ip);
endfunction

// one payload, msb first, random idle gaps between bytes
task automatic send_frame(input arp_hdr_t h, input int nbytes, input logic bad);
  logic [223:0] shift;
  int           gap;
  shift = h;
  for (int i = 0; i < nbytes; i++) begin
    gap = $unsigned($random(seed)) % 3;
    rx  = '0;
    repeat (gap) @(negedge clk);
    rx.data  = shift[223:216];
    rx.valid = 1'b1;
    rx.last  = (i == nbytes - 1);
    rx.err   = bad && (i == 10);
    shift    = shift << 8;
    @(negedge clk);
  end
  rx = '0;
  repeat (8) @(negedge clk); // learn scan settles
endtask

task automatic trickle_credits(input int limit);
  int n;
  n = 0;
  while (frames_done <= frames_read && n < limit) begin
    credit_cap++;
    repeat (3) @(negedge clk);
    n++;
  end
  assert (frames_done > frames_read) else stop_on_error("frame stalled with credits trickled back");
  credit_cap = NO_CAP;
endtask

task automatic get_frame(output arp_hdr_t h, output mac_t dst);
  logic [223:0] bits;
  int           n;
  n = 0;
  while (frames_done <= frames_read && n < 400) begin
    @(negedge clk);
    n++;
  end
  assert (frames_done > frames_read) else stop_on_error("timed out waiting for a tx frame");
  bits = '0;
  for (int i = 0; i < ARP_LEN; i++) begin
    bits = {bits[215:0], tx_log[rd_pos + i]};
  end
  h   = arp_hdr_t'(bits);
  dst = dst_log[frames_read];
  rd_pos += ARP_LEN;
  frames_read++;
endtask

task automatic expect_quiet(input int cycles);
  int base;
  base = tx_log.size();
  repeat (cycles) @(negedge clk);
  assert (tx_log.size() == base) else stop_on_error("unexpected bytes on tx");
endtask

// a zero first, so the same ip can be looked up again
task automatic start_lookup(input ipv4_t ip);
  ipv4_req = '0;
  repeat (2) @(negedge clk);
  ipv4_req = ip;
  @(negedge clk);
  assert (!arp_val) else report_mismatch("arp_val", wide_t'(arp_val), wide_t'(1'b0));
endtask

task automatic wait_result(output logic val_seen, output logic err_seen, input int limit);
  int n;
  n = 0;
  while (!arp_val && !arp_err && n < limit) begin
    @(negedge clk);
    n++;
  end
  assert (arp_val || arp_err) else stop_on_error("timed out waiting for arp_val or arp_err");
  val_seen = arp_val;
  err_seen = arp_err;
endtask

task automatic expect_request(input ipv4_t ip);
  arp_hdr_t got;
  mac_t     dst;
  get_frame(got, dst);
  assert (got == request_for(ip))
    else report_mismatch("request header", wide_t'(got), wide_t'(request_for(ip)));
  assert (dst == 48'hffff_ffff_ffff)
    else report_mismatch("tx_dst_mac", wide_t'(dst), wide_t'(48'hffff_ffff_ffff));
endtask

task automatic expect_hit(input ipv4_t ip, input mac_t mac);
  logic val_seen;
  logic err_seen;
  start_lookup(ip);
  wait_result(val_seen, err_seen, TABLE_DEPTH + 2);
  assert (val_seen && !err_seen) else stop_on_error("lookup of a learned ip did not hit");
  assert (mac_rsp == mac) else report_mismatch("mac_rsp", wide_t'(mac_rsp), wide_t'(mac));
  expect_quiet(40); // no request on a hit
endtask

task automatic expect_timeout(input ipv4_t ip);
  logic val_seen;
  logic err_seen;
  start_lookup(ip);
  expect_request(ip);
  wait_result(val_seen, err_seen, TIMEOUT_TICKS + 40);
  assert (err_seen && !val_seen) else stop_on_error("unanswered lookup did not end in arp_err");
  @(negedge clk);
  assert (!arp_err) else report_mismatch("arp_err", wide_t'(arp_err), wide_t'(1'b0));
endtask

// File: tb_arp_engine.sv
`timescale 1ns/100ps

module tb_arp_engine import arp_pkg::*; ();

  localparam int TABLE_DEPTH   = 4;
  localparam int TIMEOUT_TICKS = 200;
  localparam int CREDIT_MAX    = 8;
  localparam int NO_CAP        = 32'h7fff_ffff; // credits flow back freely

  typedef logic [223:0] wide_t; // fits the widest checked value

  localparam mac_t  DEV_MAC  = 48'h02_00_5e_00_00_01;
  localparam ipv4_t DEV_IP   = 32'hc0a8_0001;
  localparam mac_t  MAC_A    = 48'h02_00_00_00_00_a1;
  localparam mac_t  MAC_A2   = 48'h02_00_00_00_00_a2;
  localparam ipv4_t IP_A     = 32'hc0a8_0010;
  localparam mac_t  MAC_B    = 48'h02_00_00_00_00_b1;
  localparam mac_t  MAC_B2   = 48'h02_00_00_00_00_b2;
  localparam ipv4_t IP_B     = 32'hc0a8_0020;
  localparam ipv4_t IP_C     = 32'hc0a8_0030;
  localparam mac_t  MAC_F    = 48'h02_00_00_00_00_f1;
  localparam ipv4_t IP_F     = 32'hc0a8_0060;
  localparam mac_t  MAC_G    = 48'h02_00_00_00_00_71;
  localparam ipv4_t IP_G     = 32'hc0a8_0070;
  localparam ipv4_t IP_OTHER = 32'hc0a8_0099; // some other host
  localparam ipv4_t IP_UNKN  = 32'hc0a8_00ee; // never answers

  logic       clk = 1'b0;
  logic       fsm_rst;
  dev_t       dev;
  rx_stream_t rx;
  logic       tx_credit = 1'b0;
  ipv4_t      ipv4_req;
  tx_stream_t tx;
  mac_t       tx_dst_mac;
  mac_t       mac_rsp;
  logic       arp_val;
  logic       arp_err;

  integer seed = 32'h565b;

  // tx side bookkeeping written by the monitor
  byte_t tx_log[$];
  mac_t  dst_log[$];
  int    frames_done = 0;
  int    fpos = 0;
  mac_t  cur_dst;
  int    consumed = 0;
  int    returned = 0;

  // read side owned by the main sequence
  int frames_read = 0;
  int rd_pos = 0;
  int credit_cap = NO_CAP;

  always #4 clk = ~clk;

  arp_engine #(
    .TABLE_DEPTH   (TABLE_DEPTH),
    .TIMEOUT_TICKS (TIMEOUT_TICKS),
    .CREDIT_MAX    (CREDIT_MAX)
  ) DUT (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .dev        (dev),
    .rx         (rx),
    .tx_credit  (tx_credit),
    .ipv4_req   (ipv4_req),
    .tx         (tx),
    .tx_dst_mac (tx_dst_mac),
    .mac_rsp    (mac_rsp),
    .arp_val    (arp_val),
    .arp_err    (arp_err)
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input wide_t got, input wide_t exp);
    stop_on_error($sformatf("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp));
  endtask

  `include "tb_arp_tasks.svh"

  // tx monitor and credit return
  always @(negedge clk) begin
    tx_credit = 1'b0;
    if (!fsm_rst) begin
      if (tx.valid) begin
        consumed++;
        assert (consumed <= CREDIT_MAX + returned)
          else stop_on_error("tx sent more bytes than credits granted");
        if (fpos == 0) cur_dst = tx_dst_mac;
        assert (tx_dst_mac == cur_dst)
          else report_mismatch("tx_dst_mac", wide_t'(tx_dst_mac), wide_t'(cur_dst));
        tx_log.push_back(tx.data);
        fpos++;
        assert (tx.last == (fpos == ARP_LEN))
          else report_mismatch("tx.last", wide_t'(tx.last), wide_t'(fpos == ARP_LEN));
        if (tx.last) begin
          dst_log.push_back(cur_dst);
          frames_done++;
          fpos = 0;
        end
      end
      if (returned < consumed && returned < credit_cap) begin
        tx_credit = 1'b1; // one byte credit back
        returned++;
      end
    end
  end

  initial begin
    arp_hdr_t req;
    arp_hdr_t got;
    mac_t     dst;
    logic     val_seen;
    logic     err_seen;
    int       base;
    fsm_rst  = 1'b1;
    dev      = '{mac: DEV_MAC, ip: DEV_IP};
    rx       = '0;
    ipv4_req = '0;
    repeat (4) @(negedge clk);
    fsm_rst = 1'b0;
    @(negedge clk);
    assert (!tx.valid && !tx.last && !arp_val && !arp_err)
      else stop_on_error("outputs not low after reset");

    // request for the local ip gets exactly one reply
    req = make_frame(OPER_REQUEST, MAC_A, IP_A, '0, DEV_IP);
    req.hw_type = 16'h0006; // odd fixed fields show which ones are echoed
    req.hlen    = 8'd8;
    req.proto   = 16'h0801;
    req.plen    = 8'd5;
    send_frame(req, ARP_LEN, 1'b0);
    get_frame(got, dst);
    assert (got == reply_for(req))
      else report_mismatch("reply header", wide_t'(got), wide_t'(reply_for(req)));
    assert (dst == MAC_A) else report_mismatch("tx_dst_mac", wide_t'(dst), wide_t'(MAC_A));
    expect_quiet(40);

    // request for another host is learned but not answered
    send_frame(make_frame(OPER_REQUEST, MAC_B, IP_B, '0, IP_OTHER), ARP_LEN, 1'b0);
    expect_quiet(30);
    expect_hit(IP_B, MAC_B);
    send_frame(make_frame(OPER_REQUEST, MAC_B2, IP_B, '0, IP_OTHER), ARP_LEN, 1'b0);
    expect_hit(IP_B, MAC_B2);   // same ip with a new mac

    // three more senders wrap the round robin onto the first slot
    for (int k = 0; k < 3; k++) begin
      req = make_frame(OPER_REQUEST, 48'h02_00_00_00_00_c1 + 48'(k), IP_C + 32'(k), '0, IP_OTHER);
      send_frame(req, ARP_LEN, 1'b0);
    end

    // first sender now misses and the broadcast gets answered
    start_lookup(IP_A);
    expect_request(IP_A);
    assert (!arp_val) else report_mismatch("arp_val", wide_t'(arp_val), wide_t'(1'b0));
    send_frame(make_frame(OPER_REPLY, MAC_A2, IP_A, DEV_MAC, DEV_IP), ARP_LEN, 1'b0);
    wait_result(val_seen, err_seen, TIMEOUT_TICKS);
    assert (val_seen && !err_seen) else stop_on_error("reply frame did not resolve the lookup");
    assert (mac_rsp == MAC_A2) else report_mismatch("mac_rsp", wide_t'(mac_rsp), wide_t'(MAC_A2));
    expect_quiet(30);

    expect_timeout(IP_UNKN);

    // back-pressure
    credit_cap = returned;    // everything is idle here
    base = tx_log.size();
    req = make_frame(OPER_REQUEST, MAC_F, IP_F, '0, DEV_IP);
    send_frame(req, ARP_LEN, 1'b0);
    repeat (20) @(negedge clk);
    assert (tx_log.size() - base == CREDIT_MAX)
      else report_mismatch("tx byte count", wide_t'(tx_log.size() - base), wide_t'(CREDIT_MAX));
    trickle_credits(100);
    get_frame(got, dst);
    assert (got == reply_for(req))
      else report_mismatch("reply header", wide_t'(got), wide_t'(reply_for(req)));
    assert (dst == MAC_F) else report_mismatch("tx_dst_mac", wide_t'(dst), wide_t'(MAC_F));

    // errored and short frames are dropped
    req = make_frame(OPER_REQUEST, MAC_G, IP_G, '0, DEV_IP);
    send_frame(req, ARP_LEN, 1'b1);
    send_frame(req, ARP_LEN - 1, 1'b0);
    expect_quiet(30);
    expect_timeout(IP_G);

    $display("All checks passed");
    $finish;
  end

endmodule

// File: arp_engine.sv
`timescale 1ns/100ps

module arp_engine import arp_pkg::*; #(
  parameter int TABLE_DEPTH   = 4,
  parameter int TIMEOUT_TICKS = 100000,
  parameter int CREDIT_MAX    = 8
) (
  input  logic       clk,
  input  logic       fsm_rst,
  input  dev_t       dev,
  input  rx_stream_t rx,
  input  logic       tx_credit,
  input  ipv4_t      ipv4_req,
  output tx_stream_t tx,
  output mac_t       tx_dst_mac,
  output mac_t       mac_rsp,
  output logic       arp_val,
  output logic       arp_err
);

  arp_hdr_t   rx_hdr;
  logic       rx_hdr_valid;
  arp_entry_t learn;
  logic       req_pending;
  ipv4_t      req_ip;
  logic       req_taken;
  logic       start;
  logic       busy;
  arp_hdr_t   tx_hdr;
  mac_t       dst_mac;

  // every good frame teaches its sender pair
  assign learn = '{ip: rx_hdr.spa, mac: rx_hdr.sha};

  arp_rx_parser u_rx_parser (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .rx        (rx),
    .hdr       (rx_hdr),
    .hdr_valid (rx_hdr_valid)
  );

  arp_table #(
    .TABLE_DEPTH   (TABLE_DEPTH),
    .TIMEOUT_TICKS (TIMEOUT_TICKS)
  ) u_table (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .learn       (learn),
    .learn_valid (rx_hdr_valid),
    .ipv4_req    (ipv4_req),
    .mac_rsp     (mac_rsp),
    .arp_val     (arp_val),
    .arp_err     (arp_err),
    .req_pending (req_pending),
    .req_ip      (req_ip),
    .req_taken   (req_taken)
  );

  arp_tx_select u_tx_select (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .dev         (dev),
    .hdr         (rx_hdr),
    .hdr_valid   (rx_hdr_valid),
    .req_pending (req_pending),
    .req_ip      (req_ip),
    .req_taken   (req_taken),
    .busy        (busy),
    .start       (start),
    .tx_hdr      (tx_hdr),
    .dst_mac     (dst_mac)
  );

  arp_tx_serializer #(
    .CREDIT_MAX (CREDIT_MAX)
  ) u_tx_serializer (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .start      (start),
    .tx_hdr     (tx_hdr),
    .dst_mac    (dst_mac),
    .tx_credit  (tx_credit),
    .tx         (tx),
    .tx_dst_mac (tx_dst_mac),
    .busy       (busy)
  );

endmodule

// File: arp_tx_serializer.sv
`timescale 1ns/100ps

module arp_tx_serializer import arp_pkg::*; #(
  parameter int CREDIT_MAX = 8
) (
  input  logic       clk,
  input  logic       fsm_rst,
  input  logic       start,
  input  arp_hdr_t   tx_hdr,
  input  mac_t       dst_mac,
  input  logic       tx_credit,
  output tx_stream_t tx,
  output mac_t       tx_dst_mac,
  output logic       busy
);

  localparam int CR_W = $clog2(CREDIT_MAX + 1);
  localparam logic [CR_W-1:0] CR_FULL  = CR_W'(CREDIT_MAX);
  localparam logic [4:0]      LAST_CNT = 5'(ARP_LEN - 1);

  typedef enum logic {
    ser_idle,
    ser_send
  } ser_state_t;

  ser_state_t          state;
  byte_t [ARP_LEN-1:0] shreg;   // msb byte is on the wire
  logic [4:0]          cnt;
  logic [CR_W-1:0]     credit;
  logic                emit;

  assign emit = (state == ser_send) && (credit != '0);
  assign busy = (state == ser_send);

  always_comb begin
    tx.data  = shreg[ARP_LEN-1];
    tx.valid = emit;
    tx.last  = emit && (cnt == LAST_CNT);
  end

  // credit counter, one byte costs one credit
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      credit <= CR_FULL;
    end else if (emit && !tx_credit) begin
      credit <= credit - 1'b1;
    end else if (!emit && tx_credit && credit != CR_FULL) begin
      credit <= credit + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state <= ser_idle;
      cnt   <= '0;
    end else begin
      case (state)
        ser_idle: begin
          cnt <= '0;
          if (start) begin
            shreg      <= tx_hdr;
            tx_dst_mac <= dst_mac; // held for the whole frame
            state      <= ser_send;
          end
        end
        ser_send: begin
          if (emit) begin
            shreg <= {shreg[ARP_LEN-2:0], 8'h00};
            cnt   <= cnt + 5'd1;
            if (cnt == LAST_CNT) begin
              state <= ser_idle;
            end
          end
        end
        default: state <= ser_idle;
      endcase
    end
  end

endmodule

// File: arp_tx_select.sv
`timescale 1ns/100ps

module arp_tx_select import arp_pkg::*; (
  input  logic     clk,
  input  logic     fsm_rst,
  input  dev_t     dev,
  input  arp_hdr_t hdr,
  input  logic     hdr_valid,
  input  logic     req_pending,
  input  ipv4_t    req_ip,
  output logic     req_taken,
  input  logic     busy,
  output logic     start,
  output arp_hdr_t tx_hdr,
  output mac_t     dst_mac
);

  arp_hdr_t rep_hdr;   // queued reply
  logic     rep_due;
  ipv4_t    req_tpa;   // queued request target
  logic     req_due;
  logic     reply_hit;
  logic     launch_ok;

  assign reply_hit = hdr_valid && hdr.oper == OPER_REQUEST && hdr.tpa == dev.ip;
  assign req_taken = req_pending && !req_due; // slot free, take it now
  assign launch_ok = !busy && !start;         // busy lags start by a cycle

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      rep_due <= 1'b0;
      req_due <= 1'b0;
      start   <= 1'b0;
    end else begin
      start <= 1'b0;
      if (launch_ok && rep_due) begin
        // reply goes first
        start   <= 1'b1;
        tx_hdr  <= rep_hdr;
        dst_mac <= rep_hdr.tha;
        rep_due <= 1'b0;
      end else if (launch_ok && req_due) begin
        start   <= 1'b1;
        tx_hdr  <= '{hw_type: HW_ETHERNET, proto: PROTO_IPV4, hlen: HLEN_ETHERNET,
                     plen: PLEN_IPV4, oper: OPER_REQUEST, sha: dev.mac, spa: dev.ip,
                     tha: MAC_BROADCAST, tpa: req_tpa};
        dst_mac <= MAC_BROADCAST;
        req_due <= 1'b0;
      end
      if (reply_hit) begin
        rep_due <= 1'b1; // newer reply replaces an unsent one
        rep_hdr <= '{hw_type: HW_ETHERNET, proto: hdr.proto, hlen: HLEN_ETHERNET,
                     plen: hdr.plen, oper: OPER_REPLY, sha: dev.mac, spa: dev.ip,
                     tha: hdr.sha, tpa: hdr.spa};
      end
      if (req_taken) begin
        req_due <= 1'b1;
        req_tpa <= req_ip;
      end
    end
  end

endmodule

// File: arp_table.sv
`timescale 1ns/100ps

module arp_table import arp_pkg::*; #(
  parameter int TABLE_DEPTH   = 4,
  parameter int TIMEOUT_TICKS = 100000
) (
  input  logic       clk,
  input  logic       fsm_rst,
  input  arp_entry_t learn,
  input  logic       learn_valid,
  input  ipv4_t      ipv4_req,
  output mac_t       mac_rsp,
  output logic       arp_val,
  output logic       arp_err,
  output logic       req_pending,
  output ipv4_t      req_ip,
  input  logic       req_taken
);

  localparam int IDX_W = (TABLE_DEPTH > 1) ? $clog2(TABLE_DEPTH) : 1;
  localparam int TMR_W = $clog2(TIMEOUT_TICKS + 1);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(TABLE_DEPTH - 1);
  localparam logic [TMR_W-1:0] TMR_LAST = TMR_W'(TIMEOUT_TICKS - 1);

  typedef enum logic [1:0] {
    lrn_idle,
    lrn_scan,
    lrn_write
  } lrn_state_t;

  typedef enum logic [1:0] {
    lkp_idle,
    lkp_scan,
    lkp_request,
    lkp_wait
  } lkp_state_t;

  arp_entry_t             entry [TABLE_DEPTH];
  logic [TABLE_DEPTH-1:0] ent_valid;

  lrn_state_t       lrn_state;
  arp_entry_t       lrn;       // pair being learned
  logic [IDX_W-1:0] l_idx;
  logic [IDX_W-1:0] w_idx;
  logic [IDX_W-1:0] wr_ptr;    // round robin slot for new pairs
  logic             l_match;

  lkp_state_t       lkp_state;
  logic [IDX_W-1:0] r_idx;
  logic [TMR_W-1:0] timer;
  logic             r_match;

  // invalid slots never match
  assign l_match = ent_valid[l_idx] && (entry[l_idx].ip == lrn.ip);
  assign r_match = ent_valid[r_idx] && (entry[r_idx].ip == req_ip);

  // entry storage
  always_ff @(posedge clk) begin
    if (lrn_state == lrn_write) begin
      entry[w_idx] <= lrn;
    end
  end

  // learn engine
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      lrn_state <= lrn_idle;
      ent_valid <= '0;
      wr_ptr    <= '0;
      l_idx     <= '0;
      w_idx     <= '0;
    end else begin
      case (lrn_state)
        lrn_idle: begin
          l_idx <= '0;
          if (learn_valid) begin
            lrn       <= learn;
            lrn_state <= lrn_scan;
          end
        end
        lrn_scan: begin
          if (l_match) begin
            w_idx     <= l_idx; // refresh existing ip
            lrn_state <= lrn_write;
          end else if (l_idx == LAST_IDX) begin
            w_idx     <= wr_ptr;
            wr_ptr    <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
            lrn_state <= lrn_write;
          end else begin
            l_idx <= l_idx + 1'b1;
          end
        end
        lrn_write: begin
          ent_valid[w_idx] <= 1'b1;
          lrn_state        <= lrn_idle;
        end
        default: lrn_state <= lrn_idle;
      endcase
    end
  end

  // lookup, request and timeout
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      lkp_state   <= lkp_idle;
      req_ip      <= '0;
      r_idx       <= '0;
      timer       <= '0;
      arp_val     <= 1'b0;
      arp_err     <= 1'b0;
      req_pending <= 1'b0;
    end else begin
      arp_err <= 1'b0; // single cycle pulse
      case (lkp_state)
        lkp_idle: begin
          r_idx  <= '0;
          req_ip <= ipv4_req;
          if (ipv4_req != req_ip && ipv4_req != '0) begin
            arp_val   <= 1'b0;
            lkp_state <= lkp_scan;
          end
        end
        lkp_scan: begin
          if (r_match) begin
            mac_rsp   <= entry[r_idx].mac;
            arp_val   <= 1'b1;
            lkp_state <= lkp_idle;
          end else if (r_idx == LAST_IDX) begin
            req_pending <= 1'b1; // miss, ask the network
            lkp_state   <= lkp_request;
          end else begin
            r_idx <= r_idx + 1'b1;
          end
        end
        lkp_request: begin
          timer <= '0;
          if (req_taken) begin
            req_pending <= 1'b0;
            lkp_state   <= lkp_wait;
          end
        end
        lkp_wait: begin
          timer <= timer + 1'b1;
          if (learn_valid && learn.ip == req_ip) begin
            mac_rsp   <= learn.mac;
            arp_val   <= 1'b1;
            lkp_state <= lkp_idle;
          end else if (timer == TMR_LAST) begin
            arp_err   <= 1'b1;
            lkp_state <= lkp_idle;
          end
        end
        default: lkp_state <= lkp_idle;
      endcase
    end
  end

endmodule

// File: arp_rx_parser.sv
`timescale 1ns/100ps

module arp_rx_parser import arp_pkg::*; (
  input  logic       clk,
  input  logic       fsm_rst,
  input  rx_stream_t rx,
  output arp_hdr_t   hdr,
  output logic       hdr_valid
);

  localparam logic [5:0] LAST_CNT = 6'(ARP_LEN - 1); // count seen before the final byte

  byte_t [ARP_LEN-2:0] shreg;   // first 27 bytes, oldest on top
  logic [5:0]          cnt;
  logic                err_seen;
  logic                frame_ok;

  // good frame closes on exactly the 28th byte with no error anywhere
  assign frame_ok = rx.valid && rx.last && (cnt == LAST_CNT) && !rx.err && !err_seen;

  // byte shifter
  always_ff @(posedge clk) begin
    if (rx.valid) begin
      shreg <= {shreg[ARP_LEN-3:0], rx.data};
    end
    if (frame_ok) begin
      hdr <= arp_hdr_t'({shreg, rx.data});
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      cnt       <= '0;
      err_seen  <= 1'b0;
      hdr_valid <= 1'b0;
    end else begin
      hdr_valid <= frame_ok; // one cycle after last
      if (rx.valid) begin
        if (rx.last) begin
          // good or bad, the next frame starts clean
          cnt      <= '0;
          err_seen <= 1'b0;
        end else begin
          if (cnt != '1) begin
            cnt <= cnt + 6'd1; // saturates on long frames
          end
          err_seen <= err_seen | rx.err;
        end
      end
    end
  end

endmodule

// File: arp_pkg.sv
package arp_pkg;

  // field types
  typedef logic [7:0]  byte_t;
  typedef logic [31:0] ipv4_t;
  typedef logic [47:0] mac_t;
  typedef logic [15:0] oper_t;

  // arp payload in wire order, msb goes out first
  typedef struct packed {
    logic [15:0] hw_type;
    logic [15:0] proto;
    logic [7:0]  hlen;
    logic [7:0]  plen;
    oper_t       oper;
    mac_t        sha;   // sender hw address
    ipv4_t       spa;   // sender ip
    mac_t        tha;   // target hw address
    ipv4_t       tpa;   // target ip
  } arp_hdr_t;

  // local station
  typedef struct packed {
    mac_t  mac;
    ipv4_t ip;
  } dev_t;

  // one learned ip/mac pair
  typedef struct packed {
    ipv4_t ip;
    mac_t  mac;
  } arp_entry_t;

  typedef struct packed {
    byte_t data;
    logic  valid;
    logic  last;
    logic  err;
  } rx_stream_t;

  typedef struct packed {
    byte_t data;
    logic  valid;
    logic  last;
  } tx_stream_t;

  localparam int ARP_LEN = 28; // payload bytes

  localparam logic [15:0] HW_ETHERNET   = 16'd1;
  localparam logic [15:0] PROTO_IPV4    = 16'h0800;
  localparam logic [7:0]  HLEN_ETHERNET = 8'd6;
  localparam logic [7:0]  PLEN_IPV4     = 8'd4;
  localparam oper_t       OPER_REQUEST  = 16'd1;
  localparam oper_t       OPER_REPLY    = 16'd2;
  localparam mac_t        MAC_BROADCAST = '1;

endpackage
